//--- run.sh
#!/bin/sh
# Compile and run the decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module soqpskViterbiTb -f sim.f || exit 1
OUT=$(./obj_dir/VsoqpskViterbiTb +verilator+error+limit+1000 2>&1)
echo "$OUT"
echo "$OUT" | grep -q "STATUS: PASS" && echo "Run passed" || { echo "Run failed"; exit 1; }

//--- sim.f
verilog/soqpskPkg.sv
verilog/acsBranchIf.sv
verilog/branchRouter.sv
verilog/acsUnit.sv
verilog/bestMetric4.sv
verilog/traceBackSoqpsk.sv
verilog/soqpskViterbi.sv
tests/soqpskViterbi_sva.sv
tests/soqpskViterbiTb.sv

//--- tests/soqpskViterbiTb.sv
//----------------------------------------
// Testbench for the SOQPSK trellis decoder.
// Sends random bits coded onto the branch samples, then a
// run of ones, and checks decisions, phase error and index.
//----------------------------------------
`default_nettype none

module soqpskViterbiTb
   import soqpskPkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int ROT_BITS = ROT_BITS_DEF;
   localparam int CLK_PERIOD = 8;
   localparam int SYM_CLOCKS = 4;
   localparam int RANDOM_SYMS = 600;
   localparam int ONES_SYMS = 40;
   localparam int LAG = DECISION_LAG(TB_DEPTH_DEF);
   localparam int WATCHDOG_NS =
      (RANDOM_SYMS + ONES_SYMS + LAG) * SYM_CLOCKS * CLK_PERIOD + 50 * CLK_PERIOD;
   // Truncates to +100 and -100 in the metric
   localparam logic [ROT_BITS-1:0] POS = ROT_BITS'(400);
   localparam logic [ROT_BITS-1:0] NEG = ROT_BITS'(-400);

   logic                clk;
   logic                reset;
   logic                symEn;
   logic [7:0]          decayFactor;
   logic [ROT_BITS-1:0] zeroReal, rotReal, imagVal;
   logic [1:0]          index;
   logic                decision;
   logic [ROT_BITS-1:0] phaseError;
   int                  errors;
   logic                sentBits [$];
   logic [ROT_BITS-1:0] sentPhase [$];

   // Every state sees the same coded samples
   wire [ROT_BITS-1:0] mfZr0Real = zeroReal, mfZr1Real = zeroReal,
                       mfZr2Real = zeroReal, mfZr3Real = zeroReal;
   wire [ROT_BITS-1:0] mfPr0Real = rotReal, mfPr1Real = rotReal,
                       mfPr2Real = rotReal, mfPr3Real = rotReal;
   wire [ROT_BITS-1:0] mfMr0Real = rotReal, mfMr1Real = rotReal,
                       mfMr2Real = rotReal, mfMr3Real = rotReal;
   wire [ROT_BITS-1:0] mfZr0Imag = imagVal, mfZr1Imag = imagVal,
                       mfZr2Imag = imagVal, mfZr3Imag = imagVal;
   wire [ROT_BITS-1:0] mfPr0Imag = imagVal, mfPr1Imag = imagVal,
                       mfPr2Imag = imagVal, mfPr3Imag = imagVal;
   wire [ROT_BITS-1:0] mfMr0Imag = imagVal, mfMr1Imag = imagVal,
                       mfMr2Imag = imagVal, mfMr3Imag = imagVal;

   soqpskViterbi dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before the symbol sequence finished");
      $display("STATUS: FAIL");
      $finish;
   end

   //----------------------------------------
   // Checks after strobe t
   //----------------------------------------
   task automatic checkOutputs(input int t);
      if (t >= LAG) begin
         assert (decision == sentBits[t - LAG])
            else begin
               errors++;
               $display("ERROR decision sym %0d: expected %0d, actual %0d",
                        t, sentBits[t - LAG], decision);
            end
      end
      if (t >= PHASE_LAG) begin
         assert (phaseError == sentPhase[t - PHASE_LAG])
            else begin
               errors++;
               $display("ERROR phaseError sym %0d: expected %0d, actual %0d",
                        t, sentPhase[t - PHASE_LAG], phaseError);
            end
      end
      // Equal metrics in all states tie and the lowest index wins
      if (t >= RANDOM_SYMS + 8) begin
         assert (index == 2'd0)
            else begin
               errors++;
               $display("ERROR indexStable sym %0d: expected %0d, actual %0d",
                        t, 2'd0, index);
            end
      end
   endtask

   // A 1 favours zero rotation, a 0 the rotated branch
   task automatic sendSymbol(input logic bitVal);
      logic [ROT_BITS-1:0] p;
      p = ROT_BITS'($urandom);
      @(posedge clk);
      symEn <= 1'b1;
      zeroReal <= bitVal ? POS : NEG;
      rotReal <= bitVal ? NEG : POS;
      imagVal <= p;
      @(posedge clk);
      symEn <= 1'b0;
      sentBits.push_back(bitVal);
      sentPhase.push_back(p);
      @(negedge clk);
      checkOutputs(sentBits.size() - 1);
      repeat (SYM_CLOCKS - 2) @(posedge clk);
   endtask

   initial begin
      void'($urandom(92));
      errors = 0;
      reset = 1'b1;
      symEn = 1'b0;
      decayFactor = 8'd4;
      zeroReal = '0;
      rotReal = '0;
      imagVal = '0;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      repeat (2) @(posedge clk);
      // Random bits drive the metrics through repeated normalization
      for (int i = 0; i < RANDOM_SYMS; i++) begin
         sendSymbol(1'($urandom));
      end
      for (int i = 0; i < ONES_SYMS; i++) begin
         sendSymbol(1'b1);
      end
      repeat (SYM_CLOCKS) @(posedge clk);
      $display("Run complete: %0d check errors, %0d assertion failures",
               errors, dut_i.sva_i.failCount);
      if (errors == 0 && dut_i.sva_i.failCount == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/soqpskViterbi_sva.sv
//----------------------------------------
// Concurrent checks on the decoder outputs, bound into
// the top level. Covers reset values, output timing
// against the symbol strobe and known outputs.
//----------------------------------------
`default_nettype none

module soqpskViterbiSva import soqpskPkg::*; #(
   parameter int ROT_BITS = ROT_BITS_DEF
) (
   input logic                clk,
   input logic                reset,
   input logic                symEn,
   input logic [1:0]          index,
   input logic                decision,
   input logic [ROT_BITS-1:0] phaseError
);

   timeunit 1ns;
   timeprecision 1ps;

   // Number of failed assertions
   int failCount = 0;

   // Outputs clear while in reset and on the first cycle after it
   resetClear: assert property (@(posedge clk)
      reset |=> (index == 2'd0 && !decision && phaseError == '0))
      else begin
         $error("Outputs were not cleared by reset");
         failCount++;
      end

   // Outputs move only on the clock after a strobe
   holdBetweenStrobes: assert property (@(posedge clk) disable iff (reset)
      !symEn |=> ($stable(index) && $stable(decision) && $stable(phaseError)))
      else begin
         $error("An output changed without a symbol strobe");
         failCount++;
      end

   outputsKnown: assert property (@(posedge clk) disable iff (reset)
      !$isunknown({index, decision, phaseError}))
      else begin
         $error("Decision, index or phase error is unknown out of reset");
         failCount++;
      end

endmodule

bind soqpskViterbi soqpskViterbiSva #(.ROT_BITS(ROT_BITS)) sva_i (
   .clk       (clk),
   .reset     (reset),
   .symEn     (symEn),
   .index     (index),
   .decision  (decision),
   .phaseError(phaseError)
);

`default_nettype wire

//--- verilog/acsBranchIf.sv
//----------------------------------------
// Branch inputs of one trellis state.
// The router drives the source side, one ACS unit reads
// the sink side.
//----------------------------------------
`default_nettype none

interface acsBranchIf import soqpskPkg::*; #(
   parameter int ROT_BITS = ROT_BITS_DEF
) ();

   // Rotated branch from the paired state and the zero-rotation branch
   logic [ROT_BITS-1:0] rot1Real;
   logic [ROT_BITS-1:0] rot0Real;
   logic [ROT_BITS-1:0] rot1Imag;
   logic [ROT_BITS-1:0] rot0Imag;

   modport source (output rot1Real, rot0Real, rot1Imag, rot0Imag);
   modport sink (input rot1Real, rot0Real, rot1Imag, rot0Imag);

endinterface

`default_nettype wire

//--- verilog/acsUnit.sv
//----------------------------------------
// Add-compare-select for one trellis state.
// Metrics decay each symbol and all four units renormalize
// together through the shared normalize input.
//----------------------------------------
`default_nettype none

module acsUnit import soqpskPkg::*; #(
   parameter int ROT_BITS = ROT_BITS_DEF,
   parameter int SIZE = SIZE_DEF
) (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                symEn,
   input  logic [7:0]                          decayFactor,
   acsBranchIf.sink                            br,
   input  logic signed [SIZE+METRIC_GUARD-1:0] accIn,
   input  logic                                normalize,
   output logic signed [SIZE+METRIC_GUARD-1:0] accMetric,
   output logic                                sel,
   output logic                                normReq,
   output logic [ROT_BITS-1:0]                 branchImag
);

   localparam int MW = SIZE + METRIC_GUARD;
   // Half of the positive metric range
   localparam logic signed [MW-1:0] NORM_STEP = {2'b01, {(MW-2){1'b0}}};

   logic signed [MW-1:0] zeroIn, rotIn;
   logic signed [MW-1:0] zeroSum, rotSum;
   logic                 rotWins;

   // m - m * f / 256
   function automatic logic signed [MW-1:0] decay(logic signed [MW-1:0] m, logic [7:0] f);
      logic signed [MW+8:0] prod;
      prod = m * $signed({1'b0, f});
      return m - prod[MW+7:8];
   endfunction

   // Top SIZE bits of each sample with sign extension
   assign zeroIn = {{METRIC_GUARD{br.rot0Real[ROT_BITS-1]}}, br.rot0Real[ROT_BITS-1 -: SIZE]};
   assign rotIn = {{METRIC_GUARD{br.rot1Real[ROT_BITS-1]}}, br.rot1Real[ROT_BITS-1 -: SIZE]};

   // Both candidates decay by the same factor
   assign zeroSum = decay(accMetric, decayFactor) + zeroIn;
   assign rotSum = decay(accIn, decayFactor) + rotIn;
   assign rotWins = rotSum > zeroSum;

   always_ff @(posedge clk) begin
      if (reset) begin
         accMetric <= '0;
         sel <= 1'b0;
      end else if (symEn) begin
         accMetric <= (rotWins ? rotSum : zeroSum) - (normalize ? NORM_STEP : '0);
         sel <= rotWins;
      end
   end

   // Request when the top magnitude bit of a positive metric is set
   assign normReq = ~accMetric[MW-1] & accMetric[MW-2];

   assign branchImag = rotWins ? br.rot1Imag : br.rot0Imag;

endmodule

`default_nettype wire

//--- verilog/bestMetric4.sv
//----------------------------------------
// Index of the largest of four signed path metrics.
// Two-level comparison tree with a registered result.
//----------------------------------------
`default_nettype none

module bestMetric4 import soqpskPkg::*; #(
   parameter int SIZE = SIZE_DEF
) (
   input  logic                                clk,
   input  logic                                reset,
   input  logic signed [SIZE+METRIC_GUARD-1:0] a, b, c, d,
   output logic [1:0]                          bestIndex
);

   logic signed [SIZE+METRIC_GUARD-1:0] maxAb, maxCd;
   logic                                idxAb, idxCd;

   // First level keeps the lower index on a tie
   assign idxAb = b > a;
   assign idxCd = d > c;
   assign maxAb = idxAb ? b : a;
   assign maxCd = idxCd ? d : c;

   always_ff @(posedge clk) begin
      if (reset) begin
         bestIndex <= 2'd0;
      end else if (maxCd > maxAb) begin
         bestIndex <= {1'b1, idxCd};
      end else begin
         bestIndex <= {1'b0, idxAb};
      end
   end

endmodule

`default_nettype wire

//--- verilog/branchRouter.sv
//----------------------------------------
// Routes the 24 matched-filter outputs to the four states.
// Samples are latched on each symbol strobe and the rotated
// inputs follow the even/odd pairing of the trellis.
//----------------------------------------
`default_nettype none

module branchRouter import soqpskPkg::*; #(
   parameter int ROT_BITS = ROT_BITS_DEF
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                symEn,
   input  logic [ROT_BITS-1:0] mfZr0Real, mfPr0Real, mfMr0Real,
   input  logic [ROT_BITS-1:0] mfZr1Real, mfPr1Real, mfMr1Real,
   input  logic [ROT_BITS-1:0] mfZr2Real, mfPr2Real, mfMr2Real,
   input  logic [ROT_BITS-1:0] mfZr3Real, mfPr3Real, mfMr3Real,
   input  logic [ROT_BITS-1:0] mfZr0Imag, mfPr0Imag, mfMr0Imag,
   input  logic [ROT_BITS-1:0] mfZr1Imag, mfPr1Imag, mfMr1Imag,
   input  logic [ROT_BITS-1:0] mfZr2Imag, mfPr2Imag, mfMr2Imag,
   input  logic [ROT_BITS-1:0] mfZr3Imag, mfPr3Imag, mfMr3Imag,
   output logic                symEven,
   acsBranchIf.source          br0,
   acsBranchIf.source          br1,
   acsBranchIf.source          br2,
   acsBranchIf.source          br3
);

   // Symbol parity starts even
   always_ff @(posedge clk) begin
      if (reset) begin
         symEven <= 1'b1;
      end else if (symEn) begin
         symEven <= ~symEven;
      end
   end

   //----------------------------------------
   // Sample latches
   //----------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         br0.rot1Real <= '0;
         br1.rot1Real <= '0;
         br2.rot1Real <= '0;
         br3.rot1Real <= '0;
         br0.rot0Real <= '0;
         br1.rot0Real <= '0;
         br2.rot0Real <= '0;
         br3.rot0Real <= '0;
         br0.rot1Imag <= '0;
         br1.rot1Imag <= '0;
         br2.rot1Imag <= '0;
         br3.rot1Imag <= '0;
         br0.rot0Imag <= '0;
         br1.rot0Imag <= '0;
         br2.rot0Imag <= '0;
         br3.rot0Imag <= '0;
      end else if (symEn) begin
         // Rotated inputs swap partners every other symbol
         br0.rot1Real <= !symEven ? mfMr0Real : mfPr2Real;
         br1.rot1Real <= !symEven ? mfPr1Real : mfMr3Real;
         br2.rot1Real <= !symEven ? mfPr3Real : mfMr1Real;
         br3.rot1Real <= !symEven ? mfMr2Real : mfPr0Real;
         br0.rot1Imag <= !symEven ? mfMr0Imag : mfPr2Imag;
         br1.rot1Imag <= !symEven ? mfPr1Imag : mfMr3Imag;
         br2.rot1Imag <= !symEven ? mfPr3Imag : mfMr1Imag;
         br3.rot1Imag <= !symEven ? mfMr2Imag : mfPr0Imag;
         // Zero rotation of the paired state
         br0.rot0Real <= mfZr3Real;
         br1.rot0Real <= mfZr2Real;
         br2.rot0Real <= mfZr0Real;
         br3.rot0Real <= mfZr1Real;
         br0.rot0Imag <= mfZr3Imag;
         br1.rot0Imag <= mfZr2Imag;
         br2.rot0Imag <= mfZr0Imag;
         br3.rot0Imag <= mfZr1Imag;
      end
   end

endmodule

`default_nettype wire

//--- verilog/soqpskPkg.sv
//----------------------------------------
// Shared constants for the SOQPSK trellis decoder.
// Widths, traceback depth and latencies used by the RTL
// modules and by the testbench files.
//----------------------------------------
`default_nettype none

package soqpskPkg;

   // Sample and metric widths
   localparam int ROT_BITS_DEF = 10;
   localparam int SIZE_DEF = 8;
   localparam int METRIC_GUARD = 4;
   localparam int NUM_STATES = 4;

   // Path metric at the default widths
   typedef logic signed [SIZE_DEF+METRIC_GUARD-1:0] metricT;

   // Traceback depth in symbols
   localparam int TB_DEPTH_DEF = 16;

   // Symbols from imaginary input to phase error output
   localparam int PHASE_LAG = 2;

   // Symbols from a symbol's inputs to its decision
   function automatic int DECISION_LAG(int depth);
      return depth + 3;
   endfunction

   // Cross predecessor of a state for the even or odd pairing
   function automatic logic [1:0] crossState(logic [1:0] state, logic even);
      return even ? (state ^ 2'd2) : (state ^ 2'd1);
   endfunction

endpackage

`default_nettype wire

//--- verilog/soqpskViterbi.sv
//----------------------------------------
// SOQPSK 4-state trellis decoder, top level.
// Takes matched-filter outputs on each symbol strobe and
// returns the best state, hard decisions and the phase error
// for the carrier loop.
//----------------------------------------
`default_nettype none

module soqpskViterbi import soqpskPkg::*; #(
   parameter int ROT_BITS = ROT_BITS_DEF,
   parameter int SIZE = SIZE_DEF,
   parameter int TB_DEPTH = TB_DEPTH_DEF
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                symEn,
   input  logic [7:0]          decayFactor,
   input  logic [ROT_BITS-1:0] mfZr0Real, mfPr0Real, mfMr0Real,
   input  logic [ROT_BITS-1:0] mfZr1Real, mfPr1Real, mfMr1Real,
   input  logic [ROT_BITS-1:0] mfZr2Real, mfPr2Real, mfMr2Real,
   input  logic [ROT_BITS-1:0] mfZr3Real, mfPr3Real, mfMr3Real,
   input  logic [ROT_BITS-1:0] mfZr0Imag, mfPr0Imag, mfMr0Imag,
   input  logic [ROT_BITS-1:0] mfZr1Imag, mfPr1Imag, mfMr1Imag,
   input  logic [ROT_BITS-1:0] mfZr2Imag, mfPr2Imag, mfMr2Imag,
   input  logic [ROT_BITS-1:0] mfZr3Imag, mfPr3Imag, mfMr3Imag,
   output logic [1:0]          index,
   output logic                decision,
   output logic [ROT_BITS-1:0] phaseError
);

   localparam int MW = SIZE + METRIC_GUARD;

   logic signed [MW-1:0]  accMetric [NUM_STATES];
   logic signed [MW-1:0]  accCross [NUM_STATES];
   logic [ROT_BITS-1:0]   branchImag [NUM_STATES];
   logic [ROT_BITS-1:0]   imagDly [NUM_STATES];
   logic [NUM_STATES-1:0] sel, selDly, normReq;
   logic                  normalize;
   logic                  symEven;
   logic [1:0]            bestIndex;

   acsBranchIf #(.ROT_BITS(ROT_BITS)) br [NUM_STATES] ();

   branchRouter #(.ROT_BITS(ROT_BITS)) router_i (
      .*,
      .br0(br[0]),
      .br1(br[1]),
      .br2(br[2]),
      .br3(br[3])
   );

   // Shared renormalization
   assign normalize = |normReq;

   //----------------------------------------
   // ACS units with cross-feed muxes
   //----------------------------------------
   for (genvar i = 0; i < NUM_STATES; i++) begin : gAcs
      assign accCross[i] = accMetric[crossState(2'(i), symEven)];

      acsUnit #(.ROT_BITS(ROT_BITS), .SIZE(SIZE)) acs_i (
         .clk        (clk),
         .reset      (reset),
         .symEn      (symEn),
         .decayFactor(decayFactor),
         .br         (br[i]),
         .accIn      (accCross[i]),
         .normalize  (normalize),
         .accMetric  (accMetric[i]),
         .sel        (sel[i]),
         .normReq    (normReq[i]),
         .branchImag (branchImag[i])
      );
   end

   bestMetric4 #(.SIZE(SIZE)) best_i (
      .clk      (clk),
      .reset    (reset),
      .a        (accMetric[0]),
      .b        (accMetric[1]),
      .c        (accMetric[2]),
      .d        (accMetric[3]),
      .bestIndex(bestIndex)
   );

   // Symbol-rate alignment of select bits, index and phase error
   always_ff @(posedge clk) begin
      if (reset) begin
         selDly <= '0;
         index <= 2'd0;
         phaseError <= '0;
         for (int i = 0; i < NUM_STATES; i++) begin
            imagDly[i] <= '0;
         end
      end else if (symEn) begin
         selDly <= sel;
         index <= bestIndex;
         // Winner of the symbol now taken into index
         phaseError <= imagDly[bestIndex];
         for (int i = 0; i < NUM_STATES; i++) begin
            imagDly[i] <= branchImag[i];
         end
      end
   end

   traceBackSoqpsk #(.TB_DEPTH(TB_DEPTH)) trace_i (
      .clk     (clk),
      .reset   (reset),
      .symEn   (symEn),
      .symEven (symEven),
      .sel     (selDly),
      .index   (index),
      .decision(decision)
   );

endmodule

`default_nettype wire

//--- verilog/traceBackSoqpsk.sv
//----------------------------------------
// Survivor memory and traceback for the 4-state trellis.
// Each symbol stores one column of select bits with its
// parity and emits the decision of the oldest column.
//----------------------------------------
`default_nettype none

module traceBackSoqpsk import soqpskPkg::*; #(
   parameter int TB_DEPTH = TB_DEPTH_DEF
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  symEn,
   input  logic                  symEven,
   input  logic [NUM_STATES-1:0] sel,
   input  logic [1:0]            index,
   output logic                  decision
);

   localparam int PW = (TB_DEPTH > 1) ? $clog2(TB_DEPTH) : 1;

   logic [NUM_STATES-1:0] selMem [TB_DEPTH];
   logic                  evenMem [TB_DEPTH];
   logic [PW-1:0]         wrPtr;
   logic                  oldestRot;

   //----------------------------------------
   // Traceback walk
   //----------------------------------------
   // Starts at the incoming column and ends at the slot about to
   // be overwritten
   always_comb begin
      logic [1:0] state;
      int         rdIdx;
      state = sel[index] ? crossState(index, symEven) : index;
      oldestRot = 1'b0;
      for (int j = 0; j < TB_DEPTH; j++) begin
         rdIdx = (int'(wrPtr) + TB_DEPTH - 1 - j) % TB_DEPTH;
         oldestRot = selMem[rdIdx][state];
         if (oldestRot) begin
            state = crossState(state, evenMem[rdIdx]);
         end
      end
   end

   // Circular survivor memory
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int k = 0; k < TB_DEPTH; k++) begin
            selMem[k] <= '0;
            evenMem[k] <= 1'b0;
         end
      end else if (symEn) begin
         selMem[wrPtr] <= sel;
         evenMem[wrPtr] <= symEven;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wrPtr <= '0;
         decision <= 1'b0;
      end else if (symEn) begin
         // Zero-rotation survivor decodes as 1
         decision <= ~oldestRot;
         if (wrPtr == PW'(TB_DEPTH - 1)) begin
            wrPtr <= '0;
         end else begin
            wrPtr <= wrPtr + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire
